// File: all.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/cpu_bus_if.sv
verilog/regfile.sv
verilog/instr_fetch.sv
verilog/decode_issue.sv
verilog/instr_exec.sv
verilog/cpu_core.sv
verilog/cpu_top.sv
testbench/cpu_core_checker.sv
testbench/tb_cpu_top.sv

// File: testbench/cpu_core_checker.sv
`timescale 1ns/1ps

module cpu_core_checker (
	input logic                 clk,
	input logic                 rst,
	input logic                 ibus_read,
	input cpu_isa_pkg::uint32_t ibus_address,
	input logic                 ibus_stall,
	input logic                 dbus_read,
	input logic                 dbus_write,
	input cpu_isa_pkg::uint32_t dbus_address,
	input cpu_isa_pkg::uint32_t dbus_wrdata,
	input logic                 dbus_stall
);

	int violations = 0;

	dbus_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(dbus_read && dbus_write))
	else begin
		violations++;
		$error("dbus read and write high together");
	end

	ibus_aligned: assert property (@(posedge clk) disable iff (rst)
		ibus_read |-> ibus_address[1:0] == 2'b00)
	else begin
		violations++;
		$error("ibus address not word aligned");
	end

	dbus_aligned: assert property (@(posedge clk) disable iff (rst)
		(dbus_read || dbus_write) |-> dbus_address[1:0] == 2'b00)
	else begin
		violations++;
		$error("dbus address not word aligned");
	end

	// request frozen while the slave stalls
	ibus_hold: assert property (@(posedge clk) disable iff (rst)
		(ibus_read && ibus_stall) |=> (ibus_read && $stable(ibus_address)))
	else begin
		violations++;
		$error("ibus request changed during stall");
	end

	dbus_hold: assert property (@(posedge clk) disable iff (rst)
		((dbus_read || dbus_write) && dbus_stall) |=>
		($stable(dbus_read) && $stable(dbus_write) &&
		$stable(dbus_address) && $stable(dbus_wrdata)))
	else begin
		violations++;
		$error("dbus request changed during stall");
	end

endmodule

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

	typedef struct {
		string                name;
		cpu_isa_pkg::uint32_t addr;
		cpu_isa_pkg::uint32_t data;
	} store_entry_t;

	// stores on a skipped branch path land here
	localparam cpu_isa_pkg::uint32_t TRAP_ADDR = 32'h0000_03fc;
	localparam logic [63:0] PRODUCT = 64'hffff_fffe * 64'hf0f0_0ff0;

	logic                 clk;
	logic                 rst;
	logic                 ibus_read;
	cpu_isa_pkg::uint32_t ibus_address;
	cpu_isa_pkg::uint32_t ibus_rddata;
	logic                 ibus_stall;
	logic                 dbus_read;
	logic                 dbus_write;
	cpu_isa_pkg::uint32_t dbus_address;
	cpu_isa_pkg::uint32_t dbus_wrdata;
	cpu_isa_pkg::uint32_t dbus_rddata;
	logic                 dbus_stall;

	cpu_isa_pkg::uint32_t prog[$];
	cpu_isa_pkg::uint32_t dmem[256];
	store_entry_t         expected[$];
	cpu_isa_pkg::uint32_t seen_addr[$];
	cpu_isa_pkg::uint32_t seen_data[$];

	int seed = 28158;
	bit stalls_on;
	bit timed_out;
	int pass_count;
	int fail_count;

	cpu_top i_cpu_top (
		.clk,
		.rst,
		.ibus_read,
		.ibus_address,
		.ibus_rddata,
		.ibus_stall,
		.dbus_read,
		.dbus_write,
		.dbus_address,
		.dbus_wrdata,
		.dbus_rddata,
		.dbus_stall
	);

	bind cpu_core cpu_core_checker i_core_checker (
		.clk,
		.rst,
		.ibus_read    ( ibus.read    ),
		.ibus_address ( ibus.address ),
		.ibus_stall   ( ibus.stall   ),
		.dbus_read    ( dbus.read    ),
		.dbus_write   ( dbus.write   ),
		.dbus_address ( dbus.address ),
		.dbus_wrdata  ( dbus.wrdata  ),
		.dbus_stall   ( dbus.stall   )
	);

	function automatic cpu_isa_pkg::uint32_t r_format(
		input logic [5:0]             funct,
		input cpu_isa_pkg::reg_addr_t rd,
		input cpu_isa_pkg::reg_addr_t rs,
		input cpu_isa_pkg::reg_addr_t rt,
		input logic [4:0]             shamt
	);
		return {cpu_isa_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
	endfunction

	function automatic cpu_isa_pkg::uint32_t i_format(
		input logic [5:0]             opcode,
		input cpu_isa_pkg::reg_addr_t rs,
		input cpu_isa_pkg::reg_addr_t rt,
		input logic [15:0]            imm
	);
		return {opcode, rs, rt, imm};
	endfunction

	// power-up data memory, unique per byte address
	function automatic cpu_isa_pkg::uint32_t fill_word(input cpu_isa_pkg::uint32_t addr);
		return 32'hc0de_0000 ^ addr;
	endfunction

	task automatic check_addr(
		input  string                name,
		input  cpu_isa_pkg::uint32_t exp_val,
		input  cpu_isa_pkg::uint32_t act_val,
		output bit                   ok
	);
		ok = (act_val === exp_val);
		if (!ok) begin
			$display("ERR %s: address expected %h actual %h", name, exp_val, act_val);
		end
	endtask

	task automatic check_word(
		input  string                name,
		input  cpu_isa_pkg::uint32_t exp_val,
		input  cpu_isa_pkg::uint32_t act_val,
		output bit                   ok
	);
		ok = (act_val === exp_val);
		if (!ok) begin
			$display("ERR %s: data expected %h actual %h", name, exp_val, act_val);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// bus responses for the cycle that just began, only to a raised read
	always @(posedge clk) begin
		#2;
		ibus_stall = stalls_on && (($random(seed) & 3) == 0);
		dbus_stall = stalls_on && (($random(seed) & 3) == 0);
		if (ibus_read && (ibus_address >> 2) < prog.size()) begin
			ibus_rddata = prog[ibus_address >> 2];
		end else begin
			ibus_rddata = cpu_isa_pkg::NOP_WORD;
		end
		dbus_rddata = dbus_read ? dmem[dbus_address[9:2]] : 'x;
	end

	// a store completes in a cycle without stall
	always @(negedge clk) begin
		if (!rst && dbus_write && !dbus_stall) begin
			dmem[dbus_address[9:2]] = dbus_wrdata;
			if (dbus_address == TRAP_ADDR) begin
				$display("unexpected store from a skipped branch path, data %h", dbus_wrdata);
				fail_count++;
			end else begin
				seen_addr.push_back(dbus_address);
				seen_data.push_back(dbus_wrdata);
			end
		end
	end

	task automatic run_program(input bit with_stalls);
		int    limit;
		int    cycles;
		bit    ok;
		string name;

		limit = 4 * (prog.size() + expected.size()) + 200;
		cycles = 0;
		@(posedge clk);
		#2;
		rst = 1'b1;
		stalls_on = with_stalls;
		@(negedge clk);
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fill_word(i * 4);
		end
		seen_addr.delete();
		seen_data.delete();
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		while (seen_addr.size() < expected.size() && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (seen_addr.size() < expected.size()) begin
			$display("timeout: program did not finish");
			timed_out = 1'b1;
			fail_count++;
		end else begin
			foreach (expected[t]) begin
				name = with_stalls ? {expected[t].name, "_stall"} : expected[t].name;
				check_addr(name, expected[t].addr, seen_addr[t], ok);
				if (ok) begin
					check_word(name, expected[t].data, seen_data[t], ok);
				end
				if (ok) begin
					$display("ok %s: %h at %h", name, seen_data[t], seen_addr[t]);
					pass_count++;
				end else begin
					fail_count++;
				end
			end
		end
	endtask

	initial begin
		rst         = 1'b1;
		ibus_rddata = '0;
		ibus_stall  = 1'b0;
		dbus_rddata = '0;
		dbus_stall  = 1'b0;
		stalls_on   = 1'b0;
		timed_out   = 1'b0;
		pass_count  = 0;
		fail_count  = 0;

		prog = '{
			// $1 = 12345678, $2 = f0f00ff0
			i_format(cpu_isa_pkg::OP_LUI, 0, 1, 16'h1234),
			i_format(cpu_isa_pkg::OP_ORI, 1, 1, 16'h5678),
			i_format(cpu_isa_pkg::OP_LUI, 0, 2, 16'hf0f0),
			i_format(cpu_isa_pkg::OP_ORI, 2, 2, 16'h0ff0),
			r_format(cpu_isa_pkg::FN_AND, 3, 1, 2, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 3, 16'h0000),
			r_format(cpu_isa_pkg::FN_OR, 4, 1, 2, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 4, 16'h0004),
			r_format(cpu_isa_pkg::FN_XOR, 5, 1, 2, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 5, 16'h0008),
			r_format(cpu_isa_pkg::FN_SUBU, 6, 1, 2, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 6, 16'h000c),
			r_format(cpu_isa_pkg::FN_SLT, 7, 2, 1, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 7, 16'h0010),
			r_format(cpu_isa_pkg::FN_SLL, 9, 0, 1, 4),
			i_format(cpu_isa_pkg::OP_SW, 0, 9, 16'h0014),
			i_format(cpu_isa_pkg::OP_ADDIU, 1, 10, 16'hfff0),
			i_format(cpu_isa_pkg::OP_SW, 0, 10, 16'h0018),
			i_format(cpu_isa_pkg::OP_LUI, 0, 11, 16'hffff),
			i_format(cpu_isa_pkg::OP_ORI, 11, 11, 16'hfffe),
			r_format(cpu_isa_pkg::FN_ADDU, 12, 11, 1, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 12, 16'h001c),
			i_format(cpu_isa_pkg::OP_LUI, 0, 13, 16'hbeef),
			i_format(cpu_isa_pkg::OP_SW, 0, 13, 16'h0020),
			i_format(cpu_isa_pkg::OP_SW, 0, 1, 16'h0024),
			// dependent chains
			i_format(cpu_isa_pkg::OP_ADDIU, 0, 14, 16'h0007),
			i_format(cpu_isa_pkg::OP_ADDIU, 14, 14, 16'h0009),
			r_format(cpu_isa_pkg::FN_ADDU, 15, 14, 14, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 15, 16'h0028),
			i_format(cpu_isa_pkg::OP_ADDIU, 0, 16, 16'h0100),
			i_format(cpu_isa_pkg::OP_ADDIU, 0, 17, 16'h0003),
			r_format(cpu_isa_pkg::FN_ADDU, 18, 16, 17, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 18, 16'h002c),
			i_format(cpu_isa_pkg::OP_LW, 0, 19, 16'h0200),
			i_format(cpu_isa_pkg::OP_SW, 0, 19, 16'h0030),
			// branch, delay slot, then a store that must be skipped or kept
			i_format(cpu_isa_pkg::OP_BEQ, 14, 14, 16'h0002),
			i_format(cpu_isa_pkg::OP_SW, 0, 14, 16'h0034),
			i_format(cpu_isa_pkg::OP_SW, 0, 15, 16'h03fc),
			i_format(cpu_isa_pkg::OP_BNE, 14, 14, 16'h0002),
			i_format(cpu_isa_pkg::OP_SW, 0, 15, 16'h0038),
			i_format(cpu_isa_pkg::OP_SW, 0, 18, 16'h003c),
			i_format(cpu_isa_pkg::OP_BNE, 14, 15, 16'h0002),
			i_format(cpu_isa_pkg::OP_SW, 0, 16, 16'h0040),
			i_format(cpu_isa_pkg::OP_SW, 0, 15, 16'h03fc),
			i_format(cpu_isa_pkg::OP_BEQ, 14, 15, 16'h0002),
			i_format(cpu_isa_pkg::OP_SW, 0, 17, 16'h0044),
			i_format(cpu_isa_pkg::OP_SW, 0, 12, 16'h0048),
			r_format(cpu_isa_pkg::FN_MULTU, 0, 11, 2, 0),
			r_format(cpu_isa_pkg::FN_MFHI, 21, 0, 0, 0),
			r_format(cpu_isa_pkg::FN_MFLO, 22, 0, 0, 0),
			i_format(cpu_isa_pkg::OP_SW, 0, 21, 16'h004c),
			i_format(cpu_isa_pkg::OP_SW, 0, 22, 16'h0050),
			i_format(cpu_isa_pkg::OP_ADDIU, 0, 0, 16'h0055),
			i_format(cpu_isa_pkg::OP_SW, 0, 0, 16'h0054)
		};

		expected = '{
			'{"and",         32'h0000_0000, 32'h1030_0670},
			'{"or",          32'h0000_0004, 32'hf2f4_5ff8},
			'{"xor",         32'h0000_0008, 32'he2c4_5988},
			'{"subu",        32'h0000_000c, 32'h2144_4688},
			'{"slt",         32'h0000_0010, 32'h0000_0001},
			'{"sll",         32'h0000_0014, 32'h2345_6780},
			'{"addiu",       32'h0000_0018, 32'h1234_5668},
			'{"addu_wrap",   32'h0000_001c, 32'h1234_5676},
			'{"lui",         32'h0000_0020, 32'hbeef_0000},
			'{"ori",         32'h0000_0024, 32'h1234_5678},
			'{"fwd_ex",      32'h0000_0028, 32'h0000_0020},
			'{"fwd_mem",     32'h0000_002c, 32'h0000_0103},
			'{"load_use",    32'h0000_0030, fill_word(32'h0000_0200)},
			'{"beq_slot",    32'h0000_0034, 32'h0000_0010},
			'{"bne_nt_slot", 32'h0000_0038, 32'h0000_0020},
			'{"bne_nt_fall", 32'h0000_003c, 32'h0000_0103},
			'{"bne_slot",    32'h0000_0040, 32'h0000_0100},
			'{"beq_nt_slot", 32'h0000_0044, 32'h0000_0003},
			'{"beq_nt_fall", 32'h0000_0048, 32'h1234_5676},
			'{"mfhi",        32'h0000_004c, PRODUCT[63:32]},
			'{"mflo",        32'h0000_0050, PRODUCT[31:0]},
			'{"reg_zero",    32'h0000_0054, 32'h0000_0000}
		};

		// first with an always-ready memory, then with random stalls
		run_program(1'b0);
		if (!timed_out) begin
			run_program(1'b1);
		end

		$display("passed %0d, failed %0d, assertion failures %0d", pass_count, fail_count,
			i_cpu_top.i_core.i_core_checker.violations);
		if (fail_count == 0 && !timed_out && i_cpu_top.i_core.i_core_checker.violations == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verilog/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_ibus_if;
	logic                 read;
	cpu_isa_pkg::uint32_t address;
	cpu_isa_pkg::uint32_t rddata;
	logic                 stall;

	modport master(output read, output address, input rddata, input stall);
	modport slave(input read, input address, output rddata, output stall);
endinterface

interface cpu_dbus_if;
	logic                 read;
	logic                 write;
	cpu_isa_pkg::uint32_t address;
	cpu_isa_pkg::uint32_t wrdata;
	cpu_isa_pkg::uint32_t rddata;
	logic                 stall;

	modport master(
		output read, output write, output address, output wrdata,
		input rddata, input stall
	);
	modport slave(
		input read, input write, input address, input wrdata,
		output rddata, output stall
	);
endinterface

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input  logic       clk,
	input  logic       rst,
	cpu_ibus_if.master ibus,
	cpu_dbus_if.master dbus
);

	logic bus_stall, load_use, stall_id;
	logic store_done;

	cpu_isa_pkg::uint32_t           fetch_pc, if_id_pc;
	cpu_isa_pkg::instr_t            fetch_word, if_id_word;
	cpu_pipe_pkg::pipeline_decode_t decoded, id_ex;
	cpu_pipe_pkg::pipeline_exec_t   executed, ex_mem;
	cpu_pipe_pkg::pipeline_wb_t     wb;
	cpu_pipe_pkg::branch_resolved_t resolved_branch;

	logic                   [0:0] reg_we;
	cpu_isa_pkg::reg_addr_t [0:0] reg_waddr;
	cpu_isa_pkg::uint32_t   [0:0] reg_wdata;
	cpu_isa_pkg::reg_addr_t [1:0] reg_raddr;
	cpu_isa_pkg::uint32_t   [1:0] reg_rdata;

	logic [63:0] hilo, hilo_fwd;

	// an idle dbus cannot hold the pipeline
	assign bus_stall = ibus.stall | (dbus.stall & (dbus.read | dbus.write));
	assign stall_id  = bus_stall | load_use;

	instr_fetch i_fetch (
		.clk,
		.rst,
		.stall           ( stall_id              ),
		.flush           ( resolved_branch.valid ),
		.resolved_branch ( resolved_branch       ),
		.ibus,
		.fetch_pc        ( fetch_pc              ),
		.fetch_word      ( fetch_word            )
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			if_id_pc   <= cpu_pipe_pkg::RESET_PC;
			if_id_word <= cpu_isa_pkg::NOP_WORD;
		end else if (!stall_id) begin
			if_id_pc   <= fetch_pc;
			if_id_word <= fetch_word;
		end
	end

	decode_issue i_decode (
		.fetch_word ( if_id_word ),
		.fetch_pc   ( if_id_pc   ),
		.reg_raddr  ( reg_raddr  ),
		.reg_rdata  ( reg_rdata  ),
		.pipe_exec  ( executed   ),
		.pipe_mem   ( wb         ),
		.decoded    ( decoded    ),
		.stall_req  ( load_use   )
	);

	// load-use inserts a bubble into EX
	always_ff @(posedge clk) begin
		if (rst || (load_use && !bus_stall)) begin
			id_ex <= '0;
		end else if (!bus_stall) begin
			id_ex <= decoded;
		end
	end

	// MULTU in MEM has not reached HI/LO yet
	assign hilo_fwd = ex_mem.hilo_we ? ex_mem.hilo_wdata : hilo;

	instr_exec i_exec (
		.clk,
		.rst,
		.stall           ( bus_stall       ),
		.data            ( id_ex           ),
		.hilo            ( hilo_fwd        ),
		.result          ( executed        ),
		.resolved_branch ( resolved_branch )
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem <= '0;
		end else if (!bus_stall) begin
			ex_mem <= executed;
		end
	end

	// store already taken by the dbus while the ibus holds the pipeline
	always_ff @(posedge clk) begin
		if (rst || !bus_stall) begin
			store_done <= 1'b0;
		end else if (dbus.write && !dbus.stall) begin
			store_done <= 1'b1;
		end
	end

	assign dbus.read    = ex_mem.is_load;
	assign dbus.write   = ex_mem.is_store && !store_done;
	assign dbus.address = ex_mem.result;
	assign dbus.wrdata  = ex_mem.store_data;

	always_comb begin
		wb.dest  = ex_mem.dest;
		wb.wdata = ex_mem.is_load ? dbus.rddata : ex_mem.result;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hilo <= '0;
		end else if (!bus_stall && ex_mem.hilo_we) begin
			hilo <= ex_mem.hilo_wdata;
		end
	end

	assign reg_we[0]    = !bus_stall;
	assign reg_waddr[0] = wb.dest;
	assign reg_wdata[0] = wb.wdata;

	regfile #(
		.READ_PORTS  ( 2 ),
		.WRITE_PORTS ( 1 )
	) i_regfile (
		.clk,
		.rst,
		.we    ( reg_we    ),
		.waddr ( reg_waddr ),
		.wdata ( reg_wdata ),
		.raddr ( reg_raddr ),
		.rdata ( reg_rdata )
	);

endmodule

// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	localparam int REG_NUM = 32;
	localparam logic [31:0] NOP_WORD = 32'h0000_0000;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_SLT   = 6'h2a;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

endpackage

// File: verilog/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	localparam cpu_isa_pkg::uint32_t RESET_PC = 32'h0000_0000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI,
		ALU_HILO
	} alu_op_t;

	typedef struct packed {
		cpu_isa_pkg::uint32_t   pc;
		alu_op_t                alu_op;
		cpu_isa_pkg::uint32_t   op1;
		cpu_isa_pkg::uint32_t   op2;
		cpu_isa_pkg::uint32_t   imm;
		cpu_isa_pkg::reg_addr_t dest;
		logic                   is_load;
		logic                   is_store;
		logic                   is_branch;
		logic                   branch_ne;
		logic                   hilo_we;
		// high half for MFHI
		logic                   hilo_sel;
	} pipeline_decode_t;

	typedef struct packed {
		cpu_isa_pkg::uint32_t   result;
		cpu_isa_pkg::reg_addr_t dest;
		logic                   is_load;
		logic                   is_store;
		cpu_isa_pkg::uint32_t   store_data;
		logic                   hilo_we;
		logic [63:0]            hilo_wdata;
	} pipeline_exec_t;

	typedef struct packed {
		cpu_isa_pkg::reg_addr_t dest;
		cpu_isa_pkg::uint32_t   wdata;
	} pipeline_wb_t;

	typedef struct packed {
		logic                 valid;
		cpu_isa_pkg::uint32_t target;
	} branch_resolved_t;

endpackage

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                 clk,
	input  logic                 rst,
	output logic                 ibus_read,
	output cpu_isa_pkg::uint32_t ibus_address,
	input  cpu_isa_pkg::uint32_t ibus_rddata,
	input  logic                 ibus_stall,
	output logic                 dbus_read,
	output logic                 dbus_write,
	output cpu_isa_pkg::uint32_t dbus_address,
	output cpu_isa_pkg::uint32_t dbus_wrdata,
	input  cpu_isa_pkg::uint32_t dbus_rddata,
	input  logic                 dbus_stall
);

	cpu_ibus_if ibus ();
	cpu_dbus_if dbus ();

	assign ibus_read    = ibus.read;
	assign ibus_address = ibus.address;
	assign ibus.rddata  = ibus_rddata;
	assign ibus.stall   = ibus_stall;

	assign dbus_read    = dbus.read;
	assign dbus_write   = dbus.write;
	assign dbus_address = dbus.address;
	assign dbus_wrdata  = dbus.wrdata;
	assign dbus.rddata  = dbus_rddata;
	assign dbus.stall   = dbus_stall;

	cpu_core i_core (
		.clk,
		.rst,
		.ibus ( ibus.master ),
		.dbus ( dbus.master )
	);

endmodule

// File: verilog/decode_issue.sv
`timescale 1ns/1ps

module decode_issue (
	input  cpu_isa_pkg::instr_t                 fetch_word,
	input  cpu_isa_pkg::uint32_t                fetch_pc,
	output cpu_isa_pkg::reg_addr_t [1:0]        reg_raddr,
	input  cpu_isa_pkg::uint32_t   [1:0]        reg_rdata,
	input  cpu_pipe_pkg::pipeline_exec_t        pipe_exec,
	input  cpu_pipe_pkg::pipeline_wb_t          pipe_mem,
	output cpu_pipe_pkg::pipeline_decode_t      decoded,
	output logic                                stall_req
);

	cpu_isa_pkg::reg_addr_t rs, rt;
	cpu_isa_pkg::uint32_t   rs_val, rt_val;
	cpu_isa_pkg::uint32_t   imm_zext;

	assign rs = fetch_word.r.rs;
	assign rt = fetch_word.i.rt;
	assign reg_raddr[0] = rs;
	assign reg_raddr[1] = rt;

	// EX result first, then MEM, then register file
	assign rs_val = (rs == '0) ? '0 :
		(pipe_exec.dest == rs) ? pipe_exec.result :
		(pipe_mem.dest == rs) ? pipe_mem.wdata : reg_rdata[0];
	assign rt_val = (rt == '0) ? '0 :
		(pipe_exec.dest == rt) ? pipe_exec.result :
		(pipe_mem.dest == rt) ? pipe_mem.wdata : reg_rdata[1];

	// load data only shows up in MEM
	assign stall_req = pipe_exec.is_load && pipe_exec.dest != '0 &&
		(pipe_exec.dest == rs || pipe_exec.dest == rt);

	assign imm_zext = {16'h0000, fetch_word.i.imm};

	always_comb begin
		decoded = '0;
		decoded.pc  = fetch_pc;
		decoded.op1 = rs_val;
		decoded.op2 = rt_val;
		decoded.imm = {{16{fetch_word.i.imm[15]}}, fetch_word.i.imm};
		case (fetch_word.i.opcode)
			cpu_isa_pkg::OP_SPECIAL: begin
				decoded.dest = fetch_word.r.rd;
				case (fetch_word.r.funct)
					cpu_isa_pkg::FN_ADDU: decoded.alu_op = cpu_pipe_pkg::ALU_ADD;
					cpu_isa_pkg::FN_SUBU: decoded.alu_op = cpu_pipe_pkg::ALU_SUB;
					cpu_isa_pkg::FN_AND:  decoded.alu_op = cpu_pipe_pkg::ALU_AND;
					cpu_isa_pkg::FN_OR:   decoded.alu_op = cpu_pipe_pkg::ALU_OR;
					cpu_isa_pkg::FN_XOR:  decoded.alu_op = cpu_pipe_pkg::ALU_XOR;
					cpu_isa_pkg::FN_SLT:  decoded.alu_op = cpu_pipe_pkg::ALU_SLT;
					cpu_isa_pkg::FN_SLL: begin
						decoded.alu_op = cpu_pipe_pkg::ALU_SLL;
						decoded.op1    = rt_val;
						decoded.op2    = {27'd0, fetch_word.r.shamt};
					end
					cpu_isa_pkg::FN_MULTU: begin
						decoded.hilo_we = 1'b1;
						decoded.dest    = '0;
					end
					cpu_isa_pkg::FN_MFHI: begin
						decoded.alu_op   = cpu_pipe_pkg::ALU_HILO;
						decoded.hilo_sel = 1'b1;
					end
					cpu_isa_pkg::FN_MFLO: decoded.alu_op = cpu_pipe_pkg::ALU_HILO;
					default: decoded.dest = '0;
				endcase
			end
			cpu_isa_pkg::OP_ADDIU: begin
				decoded.op2  = decoded.imm;
				decoded.dest = rt;
			end
			cpu_isa_pkg::OP_ORI: begin
				decoded.alu_op = cpu_pipe_pkg::ALU_OR;
				decoded.op2    = imm_zext;
				decoded.dest   = rt;
			end
			cpu_isa_pkg::OP_LUI: begin
				decoded.alu_op = cpu_pipe_pkg::ALU_LUI;
				decoded.op2    = imm_zext;
				decoded.dest   = rt;
			end
			cpu_isa_pkg::OP_LW: begin
				decoded.is_load = 1'b1;
				decoded.dest    = rt;
			end
			cpu_isa_pkg::OP_SW: decoded.is_store = 1'b1;
			cpu_isa_pkg::OP_BEQ: decoded.is_branch = 1'b1;
			cpu_isa_pkg::OP_BNE: begin
				decoded.is_branch = 1'b1;
				decoded.branch_ne = 1'b1;
			end
			default: decoded.dest = '0;
		endcase
	end

endmodule

// File: verilog/instr_exec.sv
`timescale 1ns/1ps

module instr_exec (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           stall,
	input  cpu_pipe_pkg::pipeline_decode_t data,
	input  logic [63:0]                    hilo,
	output cpu_pipe_pkg::pipeline_exec_t   result,
	output cpu_pipe_pkg::branch_resolved_t resolved_branch
);

	cpu_isa_pkg::uint32_t alu_out, mem_addr;
	logic [63:0]          product;
	logic                 operands_equal;
	logic                 in_delay_slot;

	always_comb begin
		case (data.alu_op)
			cpu_pipe_pkg::ALU_ADD:  alu_out = data.op1 + data.op2;
			cpu_pipe_pkg::ALU_SUB:  alu_out = data.op1 - data.op2;
			cpu_pipe_pkg::ALU_AND:  alu_out = data.op1 & data.op2;
			cpu_pipe_pkg::ALU_OR:   alu_out = data.op1 | data.op2;
			cpu_pipe_pkg::ALU_XOR:  alu_out = data.op1 ^ data.op2;
			cpu_pipe_pkg::ALU_SLT:  alu_out = {31'd0, $signed(data.op1) < $signed(data.op2)};
			cpu_pipe_pkg::ALU_SLL:  alu_out = data.op1 << data.op2[4:0];
			cpu_pipe_pkg::ALU_LUI:  alu_out = {data.op2[15:0], 16'h0000};
			cpu_pipe_pkg::ALU_HILO: alu_out = data.hilo_sel ? hilo[63:32] : hilo[31:0];
			default:                alu_out = '0;
		endcase
	end

	assign product  = 64'(data.op1) * 64'(data.op2);
	assign mem_addr = data.op1 + data.imm;

	always_comb begin
		result.result     = (data.is_load || data.is_store) ? mem_addr : alu_out;
		result.dest       = data.dest;
		result.is_load    = data.is_load;
		result.is_store   = data.is_store;
		result.store_data = data.op2;
		result.hilo_we    = data.hilo_we;
		result.hilo_wdata = product;
	end

	// a branch sitting in a delay slot is not taken
	always_ff @(posedge clk) begin
		if (rst) begin
			in_delay_slot <= 1'b0;
		end else if (!stall) begin
			in_delay_slot <= data.is_branch;
		end
	end

	assign operands_equal = (data.op1 == data.op2);

	always_comb begin
		resolved_branch.valid  = data.is_branch && !in_delay_slot &&
			(operands_equal ^ data.branch_ne);
		resolved_branch.target = data.pc + 32'd4 + {data.imm[29:0], 2'b00};
	end

endmodule

// File: verilog/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           stall,
	input  logic                           flush,
	input  cpu_pipe_pkg::branch_resolved_t resolved_branch,
	cpu_ibus_if.master                     ibus,
	output cpu_isa_pkg::uint32_t           fetch_pc,
	output cpu_isa_pkg::instr_t            fetch_word
);

	cpu_isa_pkg::uint32_t pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= cpu_pipe_pkg::RESET_PC;
		end else if (!stall) begin
			if (resolved_branch.valid) begin
				pc <= resolved_branch.target;
			end else begin
				pc <= pc + 32'd4;
			end
		end
	end

	// fetch every cycle, a held pc simply repeats the request
	assign ibus.read    = 1'b1;
	assign ibus.address = pc;

	assign fetch_pc = pc;

	// wrong-path word behind the delay slot
	assign fetch_word = flush ? cpu_isa_pkg::NOP_WORD : ibus.rddata;

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile #(
	parameter int READ_PORTS  = 2,
	parameter int WRITE_PORTS = 1
) (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                   [WRITE_PORTS-1:0] we,
	input  cpu_isa_pkg::reg_addr_t [WRITE_PORTS-1:0] waddr,
	input  cpu_isa_pkg::uint32_t   [WRITE_PORTS-1:0] wdata,
	input  cpu_isa_pkg::reg_addr_t [READ_PORTS-1:0]  raddr,
	output cpu_isa_pkg::uint32_t   [READ_PORTS-1:0]  rdata
);

	cpu_isa_pkg::uint32_t regs [cpu_isa_pkg::REG_NUM];

	// higher port number wins on a collision
	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else begin
			for (int w = 0; w < WRITE_PORTS; w++) begin
				if (we[w] && waddr[w] != '0) begin
					regs[waddr[w]] <= wdata[w];
				end
			end
		end
	end

	for (genvar r = 0; r < READ_PORTS; r++) begin : gen_read
		assign rdata[r] = (raddr[r] == '0) ? '0 : regs[raddr[r]];
	end

endmodule
